/* logic/etx_cfg.sv */
// ETX configuration register block
// Decodes register accesses, holds config/status/monitor state, forwards responses
`timescale 1ns/1ps
`include "etx_macros.svh"

module etx_cfg (
   input  logic              clk,
   input  logic              nreset,
   input  logic              cfg_access,  // Register traffic
   input  logic [`ETX_PW-1:0] cfg_packet,
   input  logic              tx_access,   // Data traffic for the monitor
   input  logic [`ETX_PW-1:0] tx_packet,
   input  logic              tx_wait,     // Downstream back-pressure
   input  logic              src_wait,    // From datapath
   output logic              mmu_access,
   output logic              rsp_access,  // Toward receive side
   output logic [`ETX_PW-1:0] rsp_packet,
   output logic              gpio_enable,
   output logic [8:0]        gpio_data,
   etx_ctrl_if.cfg           ctrl
);

   import etx_pkg::*;

   emesh_t      req;         // Incoming register request
   emesh_t      tx_in;       // Monitored data packet
   etx_reg_e    ofs;         // Word offset
   logic        reg_access;
   logic        reg_write;
   logic        wr_version;
   logic        wr_cfg;
   logic        wr_status;
   logic        wr_gpio;
   logic [15:0] version_q;
   logic [7:0]  cfg_lo;      // Enable, MMU, remap, ctrlmode
   logic [12:9] cfg_hi;      // Bypass, burst, GPIO mode
   logic [1:0]  status_q;    // Sticky wait and blocked bits
   logic [8:0]  gpio_q;
   logic [31:0] monitor_q;   // Accepted data accesses
   logic [31:0] sample_q;    // Last data dstaddr
   logic [31:0] rd_data;
   logic [31:0] rd_q;        // Registered readback
   emesh_t      req_q;       // Request held for the response
   emesh_t      rsp;

   //####################################################################
   // Access decode
   //####################################################################

   assign req   = pkt2emesh(cfg_packet);
   assign tx_in = pkt2emesh(tx_packet);
   assign ofs   = etx_reg_e'(req.dstaddr[5:2]);

   assign reg_access = cfg_access && req.dstaddr[19:16] == `EGROUP_MMR
                       && req.dstaddr[10:8] == `EGROUP_TX;
   assign reg_write  = reg_access & req.write;
   assign mmu_access = cfg_access && req.dstaddr[19:16] == `EGROUP_MMU
                       && !req.dstaddr[15];   // Lower half of MMU group

   assign wr_version = reg_write && ofs == E_VERSION;
   assign wr_cfg     = reg_write && ofs == ETX_CFG;
   assign wr_status  = reg_write && ofs == ETX_STATUS;
   assign wr_gpio    = reg_write && ofs == ETX_GPIO;

   //####################################################################
   // Register file
   //####################################################################

   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         version_q <= `ETX_VERSION_RESET;
         cfg_lo    <= '0;
         cfg_hi    <= '0;
         gpio_q    <= '0;
      end
      else
      begin
         if (wr_version)
            version_q <= req.data[15:0];
         if (wr_cfg)
         begin
            cfg_lo <= req.data[7:0];
            cfg_hi <= req.data[12:9];
         end
         if (wr_gpio)
            gpio_q <= req.data[8:0];
      end
   end

   // Sticky events, cleared by any write
   always_ff @(posedge clk)
   begin
      if (!nreset)
         status_q <= '0;
      else if (wr_status)
         status_q <= '0;
      else
         status_q <= status_q | {ctrl.wait_evt, ctrl.blocked_evt};
   end

   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         monitor_q <= '0;
         sample_q  <= '0;
      end
      else
      begin
         if (tx_access && !src_wait)
            monitor_q <= monitor_q + 32'd1;  // Accepted only
         if (tx_access)
            sample_q <= tx_in.dstaddr;       // Refused traffic too
      end
   end

   // Steering toward the datapath
   assign ctrl.tx_enable       = cfg_lo[0];
   assign ctrl.remap_enable    = (cfg_lo[3:2] == 2'b01);
   assign ctrl.ctrlmode        = cfg_lo[7:4];
   assign ctrl.ctrlmode_bypass = cfg_hi[9];
   assign ctrl.gpio_enable     = gpio_enable;

   assign gpio_enable = (cfg_hi[12:11] == 2'b01);
   assign gpio_data   = gpio_q;

   //####################################################################
   // Readback and response
   //####################################################################

   always_comb
   begin
      case (ofs)
         E_VERSION:   rd_data = {16'h0, version_q};
         ETX_CFG:     rd_data = {19'h0, cfg_hi, 1'b0, cfg_lo};
         ETX_STATUS:  rd_data = {30'h0, status_q};
         ETX_GPIO:    rd_data = {23'h0, gpio_q};
         ETX_MONITOR: rd_data = monitor_q;
         ETX_PACKET:  rd_data = sample_q;
         default:     rd_data = 32'h0;     // Unmapped
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         rsp_access <= 1'b0;
         req_q      <= '0;
         rd_q       <= '0;
      end
      else if (!tx_wait)                  // Hold under back-pressure
      begin
         rsp_access <= reg_access;
         if (reg_access)
         begin
            req_q <= req;
            rd_q  <= rd_data;
         end
      end
   end

   always_comb
   begin
      rsp = req_q;
      if (req_q.write)
         rsp.ctrlmode[4] = 1'b0;          // Forwarded write
      else
      begin
         rsp.write   = 1'b1;              // Read answer travels as a write
         rsp.dstaddr = req_q.srcaddr;     // Back to requester
         rsp.srcaddr = req_q.dstaddr;
         rsp.data    = rd_q;
      end
   end

   assign rsp_packet = emesh2pkt(rsp);

   // At most one register written per access
   a_wr_onehot : assert property (@(posedge clk) disable iff (!nreset)
      $onehot0({wr_version, wr_cfg, wr_status, wr_gpio}));

   // Requester holds off while the response stage is stalled
   a_no_cfg_in_wait : assert property (@(posedge clk) disable iff (!nreset)
      !(cfg_access && tx_wait));

endmodule

/* logic/etx_ctrl_if.sv */
// ETX control link between register block and datapath
// Static steering forward, status event pulses back
`timescale 1ns/1ps

interface etx_ctrl_if;

   logic       tx_enable;       // Let traffic through
   logic       remap_enable;    // Clear upper dstaddr bits
   logic       gpio_enable;     // Pins static, traffic blocked
   logic [3:0] ctrlmode;        // Substitute ctrlmode value
   logic       ctrlmode_bypass; // Use ctrlmode above
   logic       blocked_evt;     // Access arrived in GPIO mode
   logic       wait_evt;        // First cycle of tx_wait

   // Register side
   modport cfg (
      output tx_enable, remap_enable, gpio_enable, ctrlmode, ctrlmode_bypass,
      input  blocked_evt, wait_evt
   );

   // Datapath side
   modport path (
      input  tx_enable, remap_enable, gpio_enable, ctrlmode, ctrlmode_bypass,
      output blocked_evt, wait_evt
   );

endinterface

/* logic/etx_macros.svh */
// ETX configuration plane constants
// Address and packet widths, decode group codes, register offsets
`ifndef ETX_MACROS_SVH
`define ETX_MACROS_SVH

// Widths
`define ETX_AW 32                  // Address width
`define ETX_PW 104                 // Packet width is 2*AW+40

// Address decode groups
`define EGROUP_MMR 4'hF            // Register group in dstaddr[19:16]
`define EGROUP_MMU 4'hE            // MMU table group
`define EGROUP_TX  3'h1            // TX subgroup in dstaddr[10:8]

// Register word offsets in dstaddr[5:2]
`define ETX_OFS_VERSION 4'd0
`define ETX_OFS_CFG     4'd1
`define ETX_OFS_STATUS  4'd2
`define ETX_OFS_GPIO    4'd3
`define ETX_OFS_MONITOR 4'd4
`define ETX_OFS_PACKET  4'd5

`define ETX_VERSION_RESET 16'h0102 // Version after reset

`endif

/* logic/etx_path.sv */
// ETX transmit datapath stage
// Applies enable, ctrlmode override, remap and GPIO blocking; raises status events
`timescale 1ns/1ps
`include "etx_macros.svh"

module etx_path (
   input  logic              clk,
   input  logic              nreset,
   input  logic              tx_access,
   input  logic [`ETX_PW-1:0] tx_packet,
   input  logic              tx_wait,    // Downstream back-pressure
   output logic              src_wait,   // Back-pressure to source
   output logic              out_access,
   output logic [`ETX_PW-1:0] out_packet,
   etx_ctrl_if.path          ctrl
);

   import etx_pkg::*;

   emesh_t in_pkt;   // Incoming fields
   emesh_t mod_pkt;  // After steering
   emesh_t out_q;    // Output stage payload
   logic   accept;
   logic   wait_q;   // tx_wait last cycle

   //####################################################################
   // Input steering
   //####################################################################

   assign in_pkt = pkt2emesh(tx_packet);

   // Hold source in GPIO mode or under downstream wait
   assign src_wait = tx_wait | ctrl.gpio_enable;
   assign accept   = tx_access & ~src_wait;

   always_comb
   begin
      mod_pkt = in_pkt;
      if (ctrl.ctrlmode_bypass)
         mod_pkt.ctrlmode = {1'b0, ctrl.ctrlmode}; // Configured tag
      if (ctrl.remap_enable)
         mod_pkt.dstaddr[31:29] = 3'b000;          // Fold into low space
   end

   //####################################################################
   // Output stage
   //####################################################################

   always_ff @(posedge clk)
   begin
      if (!nreset)
         out_access <= 1'b0;
      else if (!tx_wait)
         out_access <= accept & ctrl.tx_enable; // Drop when disabled
   end

   // Payload loads only on accepted traffic
   always_ff @(posedge clk)
   begin
      if (!nreset)
         out_q <= '0;
      else if (accept)
         out_q <= mod_pkt;
   end

   assign out_packet = emesh2pkt(out_q);

   //####################################################################
   // Status events
   //####################################################################

   always_ff @(posedge clk)
   begin
      if (!nreset)
         wait_q <= 1'b0;
      else
         wait_q <= tx_wait;
   end

   assign ctrl.blocked_evt = tx_access & ctrl.gpio_enable; // Traffic refused
   assign ctrl.wait_evt    = tx_wait & ~wait_q;            // Rising edge of wait

   // Stalled output keeps its packet until the wait lifts
   a_out_hold : assert property (@(posedge clk) disable iff (!nreset)
      (out_access && tx_wait) |=> (out_access && $stable(out_packet)));

endmodule

/* logic/etx_pkg.sv */
// ETX shared types
// Register offsets, transfer sizes and the packet field layout
package etx_pkg;

`include "etx_macros.svh"

   // Register word offsets
   typedef enum logic [3:0] {
      E_VERSION   = `ETX_OFS_VERSION,
      ETX_CFG     = `ETX_OFS_CFG,
      ETX_STATUS  = `ETX_OFS_STATUS,
      ETX_GPIO    = `ETX_OFS_GPIO,
      ETX_MONITOR = `ETX_OFS_MONITOR,
      ETX_PACKET  = `ETX_OFS_PACKET
   } etx_reg_e;

   // Transfer size
   typedef enum logic [1:0] {
      DM_BYTE   = 2'd0,
      DM_HALF   = 2'd1,
      DM_WORD   = 2'd2,
      DM_DOUBLE = 2'd3
   } datamode_e;

   // Packet fields with MSB first
   typedef struct packed {
      logic [`ETX_AW-1:0] srcaddr;  // 103:72
      logic [`ETX_AW-1:0] data;     // 71:40
      logic [`ETX_AW-1:0] dstaddr;  // 39:8
      logic [4:0]         ctrlmode; // 7:3
      datamode_e          datamode; // 2:1
      logic               write;    // 0
   } emesh_t;

   function automatic emesh_t pkt2emesh(logic [`ETX_PW-1:0] pkt);
      return emesh_t'(pkt);
   endfunction

   function automatic logic [`ETX_PW-1:0] emesh2pkt(emesh_t pkt);
      return `ETX_PW'(pkt);
   endfunction

endpackage

/* logic/etx_top.sv */
// ETX configuration plane top
// Register block and transmit datapath joined by the control interface
`timescale 1ns/1ps
`include "etx_macros.svh"

module etx_top (
   input  logic              clk,
   input  logic              nreset,
   // Register traffic
   input  logic              cfg_access,
   input  logic [`ETX_PW-1:0] cfg_packet,
   // Data traffic
   input  logic              tx_access,
   input  logic [`ETX_PW-1:0] tx_packet,
   input  logic              tx_wait,
   // Transmitted traffic
   output logic              out_access,
   output logic [`ETX_PW-1:0] out_packet,
   output logic              src_wait,
   // Register responses
   output logic              rsp_access,
   output logic [`ETX_PW-1:0] rsp_packet,
   output logic              mmu_access,
   // Static pins
   output logic              gpio_enable,
   output logic [8:0]        gpio_data
);

   etx_ctrl_if u_ctrl ();  // Steering and status link

   etx_cfg u_cfg (
      .clk         (clk),
      .nreset      (nreset),
      .cfg_access  (cfg_access),
      .cfg_packet  (cfg_packet),
      .tx_access   (tx_access),
      .tx_packet   (tx_packet),
      .tx_wait     (tx_wait),
      .src_wait    (src_wait),   // Monitor counts accepted traffic
      .mmu_access  (mmu_access),
      .rsp_access  (rsp_access),
      .rsp_packet  (rsp_packet),
      .gpio_enable (gpio_enable),
      .gpio_data   (gpio_data),
      .ctrl        (u_ctrl.cfg)
   );

   etx_path u_path (
      .clk        (clk),
      .nreset     (nreset),
      .tx_access  (tx_access),
      .tx_packet  (tx_packet),
      .tx_wait    (tx_wait),
      .src_wait   (src_wait),
      .out_access (out_access),
      .out_packet (out_packet),
      .ctrl       (u_ctrl.path)
   );

endmodule

/* run.sh */
#!/bin/sh
# Build and run the ETX testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f tb.f --top-module tb_top -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Build failed"
   exit 1
fi
./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
if grep -q "TB FAILED" sim.log; then
   exit 1
fi
exit 0

/* tb.f */
+incdir+logic
logic/etx_pkg.sv
logic/etx_ctrl_if.sv
logic/etx_cfg.sv
logic/etx_path.sv
logic/etx_top.sv
testbench/tb_clkgen.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* testbench/tb_checker.sv */
// ETX port checker
// Models register state; compares responses and traffic
`timescale 1ns/1ps
`include "etx_macros.svh"

module tb_checker (
   input  logic              clk,
   input  logic              nreset,
   input  logic              cfg_access,
   input  logic [`ETX_PW-1:0] cfg_packet,
   input  logic              tx_access,
   input  logic [`ETX_PW-1:0] tx_packet,
   input  logic              tx_wait,
   input  logic              out_access,
   input  logic [`ETX_PW-1:0] out_packet,
   input  logic              src_wait,
   input  logic              rsp_access,
   input  logic [`ETX_PW-1:0] rsp_packet,
   input  logic              mmu_access,
   input  logic              gpio_enable,
   input  logic [8:0]        gpio_data,
   output int                err_count,
   output int                check_count
);

   localparam logic [31:0] CFG_MASK = 32'h0000_1EFF;   // Defined config fields
   // Fields checked in a read response
   localparam logic [`ETX_PW-1:0] RD_MASK = {32'h0, 64'hFFFF_FFFF_FFFF_FFFF, 8'h01};

   logic [15:0]        m_version;
   logic [31:0]        m_cfg, m_gpio, m_status, m_monitor, m_sample;
   logic               m_wait_q;                 // tx_wait one cycle back
   logic               exp_out_access, exp_rsp_access, exp_rsp_read;
   logic [`ETX_PW-1:0] exp_out_pkt, exp_rsp_pkt;

   // Value a read of word offset ofs returns
   function automatic logic [31:0] reg_value(input logic [3:0] ofs);
      case (ofs)
         4'd0:    return {16'h0, m_version};
         4'd1:    return m_cfg;
         4'd2:    return m_status;
         4'd3:    return m_gpio;
         4'd4:    return m_monitor;
         4'd5:    return m_sample;
         default: return 32'h0;      // Unmapped offsets
      endcase
   endfunction

   // Forwarded response for a register request
   function automatic logic [`ETX_PW-1:0] expect_rsp(input logic [`ETX_PW-1:0] req);
      logic [`ETX_PW-1:0] rsp;
      rsp = req;
      if (req[0])
         rsp[7] = 1'b0;                      // Write clears ctrlmode bit 4
      else
      begin
         rsp[0]     = 1'b1;
         rsp[39:8]  = req[103:72];           // Back to requester
         rsp[71:40] = reg_value(req[13:10]);
      end
      return rsp;
   endfunction

   // Steering applied by the datapath
   function automatic logic [`ETX_PW-1:0] expect_out(input logic [`ETX_PW-1:0] pkt);
      logic [`ETX_PW-1:0] res;
      res = pkt;
      if (m_cfg[9])
         res[7:3] = {1'b0, m_cfg[7:4]};      // ctrlmode override
      if (m_cfg[3:2] == 2'b01)
         res[39:37] = 3'b000;                // Remap clears dstaddr[31:29]
      return res;
   endfunction

   task automatic compare(input string name, input logic [`ETX_PW-1:0] got, exp);
      check_count++;
      if (got !== exp)
      begin
         err_count++;
         $display("ERROR t=%0t %s got %h exp %h", $time, name, got, exp);
      end
   endtask

   //######################################################################
   // Compare at each edge, then advance the model
   //######################################################################

   always @(posedge clk)
   begin
      logic               gpio_mode, swait, accept, reg_acc, mmu_exp;
      logic [`ETX_PW-1:0] mask;
      if (!nreset)
      begin
         m_version      = `ETX_VERSION_RESET;
         m_cfg          = '0;
         m_gpio         = '0;
         m_status       = '0;
         m_monitor      = '0;
         m_sample       = '0;
         m_wait_q       = 1'b0;
         exp_out_access = 1'b0;
         exp_rsp_access = 1'b0;
         exp_rsp_read   = 1'b0;
         exp_out_pkt    = '0;
         exp_rsp_pkt    = '0;
      end
      else
      begin
         gpio_mode = (m_cfg[12:11] == 2'b01);
         swait     = tx_wait | gpio_mode;
         accept    = tx_access & ~swait;
         reg_acc   = cfg_access && cfg_packet[27:24] == `EGROUP_MMR
                     && cfg_packet[18:16] == `EGROUP_TX;
         mmu_exp   = cfg_access && cfg_packet[27:24] == `EGROUP_MMU && !cfg_packet[23];
         compare("src_wait", `ETX_PW'(src_wait), `ETX_PW'(swait));
         compare("mmu_access", `ETX_PW'(mmu_access), `ETX_PW'(mmu_exp));
         compare("gpio_enable", `ETX_PW'(gpio_enable), `ETX_PW'(gpio_mode));
         compare("gpio_data", `ETX_PW'(gpio_data), `ETX_PW'(m_gpio[8:0]));
         compare("out_access", `ETX_PW'(out_access), `ETX_PW'(exp_out_access));
         if (exp_out_access)
            compare("out_packet", out_packet, exp_out_pkt);
         compare("rsp_access", `ETX_PW'(rsp_access), `ETX_PW'(exp_rsp_access));
         mask = exp_rsp_read ? RD_MASK : '1;
         if (exp_rsp_access)
            compare("rsp_packet", rsp_packet & mask, exp_rsp_pkt & mask);
         // Output stages hold under back-pressure
         if (!tx_wait)
         begin
            exp_out_access = accept & m_cfg[0];
            exp_rsp_access = reg_acc;
            if (reg_acc)
            begin
               exp_rsp_pkt  = expect_rsp(cfg_packet);
               exp_rsp_read = !cfg_packet[0];
            end
         end
         if (accept)
            exp_out_pkt = expect_out(tx_packet);
         if (accept)
            m_monitor++;                        // Accepted traffic only
         if (tx_access)
            m_sample = tx_packet[39:8];         // Last dstaddr
         if (tx_access && gpio_mode)
            m_status[0] = 1'b1;                 // Blocked traffic
         if (tx_wait && !m_wait_q)
            m_status[1] = 1'b1;                 // Wait seen
         m_wait_q = tx_wait;
         if (reg_acc && cfg_packet[0])
         begin
            case (cfg_packet[13:10])
               4'd0:    m_version = cfg_packet[55:40];
               4'd1:    m_cfg = cfg_packet[71:40] & CFG_MASK;
               4'd2:    m_status = '0;
               4'd3:    m_gpio = {23'h0, cfg_packet[48:40]};
               default: ;
            endcase
         end
      end
   end

endmodule

/* testbench/tb_clkgen.sv */
// Testbench clock and reset source
// 10 ns clock, nreset held low for the first two cycles
`timescale 1ns/1ps

module tb_clkgen (
   output logic clk,
   output logic nreset
);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   initial
   begin
      nreset = 1'b0;
      repeat (2) @(posedge clk);
      #1 nreset = 1'b1;        // Released just after the edge
   end

endmodule

/* testbench/tb_top.sv */
// ETX configuration plane testbench
// Register and data traffic driven 1 ns after the rising edge, checked by tb_checker
`timescale 1ns/1ps
`include "etx_macros.svh"

module tb_top;

   logic              clk, nreset;
   logic              cfg_access, tx_access, tx_wait;
   logic [`ETX_PW-1:0] cfg_packet, tx_packet, out_packet, rsp_packet;
   logic              out_access, src_wait, rsp_access, mmu_access, gpio_enable;
   logic [8:0]        gpio_data;
   int                err_count, check_count;
   int                timeouts, tests_run, tests_failed, fails_before;

   tb_clkgen  u_clk (.clk(clk), .nreset(nreset));
   etx_top    u_dut (.*);
   tb_checker u_chk (.*);

   // Register address from group, TX subgroup and word offset
   function automatic logic [31:0] reg_addr(input logic [3:0] grp, input logic [3:0] ofs);
      return {12'h0, grp, 5'h0, `EGROUP_TX, 2'b00, ofs, 2'b00};
   endfunction

   function automatic logic [`ETX_PW-1:0] make_pkt(input logic wr, input logic [31:0] dst,
                                                   input logic [31:0] data, src,
                                                   input logic [4:0] ctrl);
      return {src, data, dst, ctrl, 2'd2, wr};   // Word transfers
   endfunction

   // One register access; waits for the response in the register group
   task automatic reg_txn(input logic wr, input logic [3:0] grp, ofs, input logic [31:0] data);
      int n;
      cfg_access = 1'b1;
      cfg_packet = make_pkt(wr, reg_addr(grp, ofs), data, $urandom, 5'h1F);
      @(posedge clk); #1;
      cfg_access = 1'b0;
      if (grp == `EGROUP_MMR)
      begin
         n = 0;
         while (!rsp_access && n < 8)
         begin
            @(posedge clk); #1;
            n++;
         end
         if (!rsp_access)
         begin
            timeouts++;
            $display("Timeout: no response to register access at offset %0d", ofs);
         end
      end
      @(posedge clk); #1;
   endtask

   // Data traffic with optional sparse access and random back-pressure
   task automatic send_traffic(input int n, input bit rand_wait);
      repeat (n)
      begin
         tx_access = rand_wait ? ($urandom_range(0, 3) != 0) : 1'b1;
         tx_packet = make_pkt(1'b1, $urandom, $urandom, $urandom, 5'($urandom));
         tx_wait   = rand_wait ? ($urandom_range(0, 2) == 0) : 1'b0;
         @(posedge clk); #1;
      end
      tx_access = 1'b0;
      tx_wait   = 1'b0;
      repeat (2) @(posedge clk);
      #1;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (err_count + timeouts != fails_before)
         tests_failed++;
      $display("Test %0d %s: %s", tests_run, name,
               (err_count + timeouts != fails_before) ? "mismatches" : "ok");
      fails_before = err_count + timeouts;
   endtask

   initial
   begin
      int n;
      void'($urandom(89638));
      cfg_access   = 1'b0;
      cfg_packet   = '0;
      tx_access    = 1'b0;
      tx_packet    = '0;
      tx_wait      = 1'b0;
      timeouts     = 0;
      tests_run    = 0;
      tests_failed = 0;
      fails_before = 0;
      n = 0;
      while (!nreset && n < 20)
      begin
         @(posedge clk);
         n++;
      end
      if (!nreset)
      begin
         timeouts++;
         $display("Timeout: reset was never released");
      end
      @(posedge clk); #1;
      reg_txn(1'b0, `EGROUP_MMR, 4'd0, 32'h0);                   // Version
      reg_txn(1'b0, `EGROUP_MMR, 4'd1, 32'h0);                   // Config
      finish_test("reset values");
      reg_txn(1'b1, `EGROUP_MMR, 4'd1, $urandom & 32'h0000_1EFF);
      reg_txn(1'b0, `EGROUP_MMR, 4'd1, 32'h0);
      reg_txn(1'b1, `EGROUP_MMR, 4'd3, $urandom & 32'h0000_01FF);
      reg_txn(1'b0, `EGROUP_MMR, 4'd3, 32'h0);
      reg_txn(1'b1, `EGROUP_MMR, 4'd0, $urandom & 32'h0000_FFFF); // Version
      reg_txn(1'b0, `EGROUP_MMR, 4'd0, 32'h0);
      finish_test("register readback");
      reg_txn(1'b1, `EGROUP_MMR, 4'd1, 32'h0000_02A5);           // Enable, remap, bypass 0xA
      send_traffic(8, 1'b0);
      reg_txn(1'b1, `EGROUP_MMR, 4'd1, 32'h0000_02A4);           // Same setup with tx disabled
      send_traffic(6, 1'b0);
      finish_test("steering and enable");
      reg_txn(1'b1, `EGROUP_MMR, 4'd1, 32'h0000_0801);           // GPIO mode
      reg_txn(1'b1, `EGROUP_MMR, 4'd3, 32'h0000_0155);
      send_traffic(3, 1'b0);
      reg_txn(1'b0, `EGROUP_MMR, 4'd2, 32'h0);                   // Blocked bit set
      reg_txn(1'b1, `EGROUP_MMR, 4'd2, 32'h0);                   // Clear status
      reg_txn(1'b0, `EGROUP_MMR, 4'd2, 32'h0);
      finish_test("gpio blocking");
      reg_txn(1'b1, `EGROUP_MMR, 4'd1, 32'h0000_0001);
      send_traffic(40, 1'b1);
      reg_txn(1'b0, `EGROUP_MMR, 4'd4, 32'h0);                   // Monitor
      reg_txn(1'b0, `EGROUP_MMR, 4'd5, 32'h0);                   // Sampler
      finish_test("monitor under back-pressure");
      reg_txn(1'b1, `EGROUP_MMU, 4'd1, 32'h0000_1EFF);           // MMU range touches no register
      reg_txn(1'b0, `EGROUP_MMR, 4'd1, 32'h0);
      finish_test("mmu range");
      $display("Done: %0d tests, %0d failed, %0d checks, %0d errors, %0d timeouts",
               tests_run, tests_failed, check_count, err_count, timeouts);
      if (err_count == 0 && timeouts == 0 && tests_failed == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule
